// File: compile.f
verilog/tracker_pkg.sv
verilog/seq_tracker.sv
verilog/tracker_monitor.sv
verilog/tracker_apb_regs.sv
verilog/tracker_top.sv
sim/tb_tracker.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_tracker -Mdir obj_dir

output=$(./obj_dir/Vtb_tracker)
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: sim/tb_tracker.sv
`timescale 1ns/10ps

module tb_tracker;

  localparam int NumEntries = 8;
  localparam int MaxAllocSize = 3;
  localparam int EntryIdWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1;
  localparam int SizeWidth = $clog2(MaxAllocSize + 1);
  localparam int CountWidth = $clog2(NumEntries + 1);

  // Stimulus lengths that size the timeout
  localparam int ResetCycles = 16;
  localparam int FillLimit = 60;
  localparam int HoldCycles = 6;
  localparam int MixedCycles = 400;
  localparam int ApbAccesses = 9;
  localparam int PlannedCycles = 2 * ResetCycles + FillLimit + HoldCycles + MixedCycles +
                                 NumEntries + 3 * ApbAccesses + 20;
  localparam int TimeoutCycles = PlannedCycles + 200;

  logic                                      clk = 1'b0;
  logic                                      reset;
  logic [SizeWidth-1:0]                      alloc_receivable;
  logic [SizeWidth-1:0]                      alloc_sendable;
  logic [MaxAllocSize-1:0][EntryIdWidth-1:0] alloc_entry_id;
  logic                                      dealloc_valid;
  logic [SizeWidth-1:0]                      dealloc_size;
  logic [CountWidth-1:0]                     free_entry_count;
  logic [CountWidth-1:0]                     allocated_entry_count;
  tracker_pkg::apb_req_t                     apb_req;
  tracker_pkg::apb_rsp_t                     apb_rsp;

  // Model of the tracker state stepped on each rising edge
  int          m_ptr;
  int          m_count;
  int unsigned m_total;
  logic        m_enable;
  logic        m_known;

  int unsigned lcg_state;
  int          value_errors;
  int          other_errors;
  int          cycles;

  tracker_top #(
    .NumEntries  (NumEntries),
    .MaxAllocSize(MaxAllocSize)
  ) u_dut (
    .clk                  (clk),
    .reset                (reset),
    .alloc_receivable     (alloc_receivable),
    .alloc_sendable       (alloc_sendable),
    .alloc_entry_id       (alloc_entry_id),
    .dealloc_valid        (dealloc_valid),
    .dealloc_size         (dealloc_size),
    .free_entry_count     (free_entry_count),
    .allocated_entry_count(allocated_entry_count),
    .apb_req              (apb_req),
    .apb_rsp              (apb_rsp)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // Linear congruential draw in [0, limit)
  function automatic int unsigned lcg_draw(input int unsigned limit);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % limit;
  endfunction

  // Offer is the smaller of free entries and beat width
  // Zero while allocation is disabled
  function automatic int expected_sendable(input int count, input logic enable);
    int free_slots;
    free_slots = NumEntries - count;
    if (!enable) begin
      return 0;
    end
    return (free_slots < MaxAllocSize) ? free_slots : MaxAllocSize;
  endfunction

  // Lane i names the i-th sequential ID after the pointer
  function automatic int expected_lane_id(input int ptr, input int lane);
    return (ptr + lane) % NumEntries;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
    value_errors++;
    $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
  endtask

  task automatic end_run();
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // Compare DUT ports with the model and then step it
  always @(posedge clk) begin : compare_outputs
    int exp_send;
    int taken;
    int released;
    int recv;
    if (reset) begin
      m_ptr = 0;
      m_count = 0;
      m_total = 0;
      m_enable = 1'b0;
      m_known = 1'b1;
    end else begin
      if (m_known) begin
        exp_send = expected_sendable(m_count, m_enable);
        if (int'(alloc_sendable) != exp_send) begin
          report_mismatch("alloc_sendable", 32'(alloc_sendable), 32'(exp_send));
        end
        for (int i = 0; i < MaxAllocSize; i++) begin
          if (int'(alloc_entry_id[i]) != expected_lane_id(m_ptr, i)) begin
            report_mismatch($sformatf("alloc_entry_id[%0d]", i), 32'(alloc_entry_id[i]),
                            32'(expected_lane_id(m_ptr, i)));
          end
        end
        if (int'(allocated_entry_count) != m_count) begin
          report_mismatch("allocated_entry_count", 32'(allocated_entry_count), 32'(m_count));
        end
        if (int'(free_entry_count) != NumEntries - m_count) begin
          report_mismatch("free_entry_count", 32'(free_entry_count),
                          32'(NumEntries - m_count));
        end
        // Client takes the lowest lanes
        // Release drops the oldest IDs
        recv = int'(alloc_receivable);
        taken = (recv < exp_send) ? recv : exp_send;
        released = dealloc_valid ? int'(dealloc_size) : 0;
        if (released > m_count + taken) begin
          // Count after an over-release stays unmodeled until reset
          m_known = 1'b0;
        end else begin
          m_count = m_count + taken - released;
          m_ptr = (m_ptr + taken) % NumEntries;
          m_total = m_total + taken;
        end
      end
      // CTRL write lands on the edge closing the access phase
      if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
          apb_req.paddr == tracker_pkg::REG_CTRL) begin
        m_enable = apb_req.pwdata[0];
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      other_errors++;
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      end_run();
    end
  end

  task automatic apply_reset();
    reset = 1'b1;
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic drive_idle();
    alloc_receivable = '0;
    dealloc_valid = 1'b0;
    dealloc_size = '0;
  endtask

  // One APB transfer with setup and access phases, started on a falling edge
  task automatic apb_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    while (!apb_rsp.pready) begin
      @(posedge clk);
    end
    @(negedge clk);
    rdata = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, wdata, rdata, slverr);
    if (slverr) begin
      other_errors++;
      $display("APB write to offset 0x%0h was answered with a slave error", addr);
    end
  endtask

  task automatic apb_read_check(input logic [3:0] addr, input logic [31:0] expected,
                                input string name);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b0, addr, '0, rdata, slverr);
    if (slverr) begin
      other_errors++;
      $display("APB read of %s was answered with a slave error", name);
    end
    if (rdata != expected) begin
      report_mismatch(name, rdata, expected);
    end
  endtask

  initial begin
    logic [31:0]                               rdata;
    logic                                      slverr;
    logic [MaxAllocSize-1:0][EntryIdWidth-1:0] held_ids;
    logic [SizeWidth-1:0]                      held_send;
    logic [EntryIdWidth-1:0]                   held_id;
    tracker_pkg::tracker_err_t                 over_mask;
    int                                        size;
    int                                        fill_cycles;
    lcg_state = 11165;
    value_errors = 0;
    other_errors = 0;
    cycles = 0;
    reset = 1'b1;
    apb_req = '0;
    drive_idle();
    apply_reset();

    // Reset state as seen through STATUS and ERROR
    @(negedge clk);
    apb_read_check(tracker_pkg::REG_STATUS, {16'h0, 8'(NumEntries), 8'h0}, "STATUS");
    apb_read_check(tracker_pkg::REG_ERROR, 32'h0, "ERROR");

    // Enable and fill with random takes and no releases
    apb_write(tracker_pkg::REG_CTRL, 32'h1);
    fill_cycles = 0;
    while (m_count < NumEntries && fill_cycles < FillLimit) begin
      alloc_receivable = SizeWidth'(lcg_draw(MaxAllocSize + 1));
      @(negedge clk);
      fill_cycles++;
    end
    if (m_count != NumEntries) begin
      other_errors++;
      $display("Tracker did not fill within %0d cycles", FillLimit);
    end
    // Full tracker offers nothing even to an eager client
    alloc_receivable = SizeWidth'(MaxAllocSize);
    repeat (3) @(negedge clk);
    if (alloc_sendable != '0) begin
      report_mismatch("alloc_sendable", 32'(alloc_sendable), 32'h0);
    end

    // Free one beat worth and hold the client off
    alloc_receivable = '0;
    dealloc_valid = 1'b1;
    dealloc_size = SizeWidth'(MaxAllocSize);
    @(negedge clk);
    drive_idle();
    @(negedge clk);
    // Offer expected from the model before the hold starts
    held_send = SizeWidth'(expected_sendable(m_count, m_enable));
    for (int i = 0; i < MaxAllocSize; i++) begin
      held_ids[i] = EntryIdWidth'(expected_lane_id(m_ptr, i));
    end
    repeat (HoldCycles) @(negedge clk);
    if (alloc_sendable != held_send) begin
      report_mismatch("alloc_sendable", 32'(alloc_sendable), 32'(held_send));
    end
    if (alloc_entry_id != held_ids) begin
      report_mismatch("alloc_entry_id", 32'(alloc_entry_id), 32'(held_ids));
    end
    // Partial take moves lane 1 down to lane 0
    held_id = EntryIdWidth'(expected_lane_id(m_ptr, 1));
    alloc_receivable = 'd1;
    @(negedge clk);
    alloc_receivable = '0;
    if (alloc_entry_id[0] != held_id) begin
      report_mismatch("alloc_entry_id[0]", 32'(alloc_entry_id[0]), 32'(held_id));
    end

    // Mixed takes and legal in-order releases
    repeat (MixedCycles) begin
      alloc_receivable = SizeWidth'(lcg_draw(MaxAllocSize + 1));
      size = 1 + int'(lcg_draw(MaxAllocSize));
      if (size > m_count) begin
        size = m_count;
      end
      dealloc_valid = (lcg_draw(2) == 1) && (size > 0);
      dealloc_size = SizeWidth'(size);
      @(negedge clk);
    end
    drive_idle();
    @(negedge clk);
    apb_read_check(tracker_pkg::REG_ALLOC_TOTAL, m_total, "ALLOC_TOTAL");
    apb_read_check(tracker_pkg::REG_ERROR, 32'h0, "ERROR");

    // Drain and release one more than is held
    while (m_count > 0) begin
      size = (m_count < MaxAllocSize) ? m_count : MaxAllocSize;
      dealloc_valid = 1'b1;
      dealloc_size = SizeWidth'(size);
      @(negedge clk);
    end
    dealloc_valid = 1'b1;
    dealloc_size = 'd1;
    @(negedge clk);
    drive_idle();
    @(negedge clk);
    // Only the over-release flag may be set
    over_mask = '0;
    over_mask.over_release = 1'b1;
    apb_read_check(tracker_pkg::REG_ERROR, 32'(over_mask), "ERROR");
    // Write 1 to clear the flag
    apb_write(tracker_pkg::REG_ERROR, 32'(over_mask));
    apb_read_check(tracker_pkg::REG_ERROR, 32'h0, "ERROR");
    apply_reset();
    repeat (2) @(negedge clk);

    // Four-bit offsets leave no free aligned word so 0x6 stands for an unmapped offset
    apb_access(1'b0, 4'h6, '0, rdata, slverr);
    if (!slverr) begin
      other_errors++;
      $display("APB read at an unmapped offset did not raise pslverr");
    end
    end_run();
  end

endmodule

// File: verilog/seq_tracker.sv
`timescale 1ns/10ps

module seq_tracker #(
  parameter int NumEntries = 8,
  parameter int MaxAllocSize = 3,
  localparam int EntryIdWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1,
  localparam int SizeWidth = $clog2(MaxAllocSize + 1),
  localparam int CountWidth = $clog2(NumEntries + 1)
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     alloc_enable,
  // Allocation handshake
  input  logic [SizeWidth-1:0]                     alloc_receivable,
  output logic [SizeWidth-1:0]                     alloc_sendable,
  output logic [MaxAllocSize-1:0][EntryIdWidth-1:0] alloc_entry_id,
  // In-order release
  input  logic                                     dealloc_valid,
  input  logic [SizeWidth-1:0]                     dealloc_size,
  // Occupancy
  output logic [CountWidth-1:0]                    free_entry_count,
  output logic [CountWidth-1:0]                    allocated_entry_count
);

  // Next ID to hand out and number of IDs held
  // Oldest held ID sits allocated_count entries behind alloc_ptr
  logic [EntryIdWidth-1:0] alloc_ptr;
  logic [CountWidth-1:0]   allocated_count;

  logic [SizeWidth-1:0]    taken_count;
  logic [SizeWidth-1:0]    released_count;
  logic [CountWidth:0]     count_grow;
  logic [CountWidth-1:0]   count_next;
  logic                    over_release;
  logic [EntryIdWidth-1:0] alloc_ptr_next;

  // Pointer step with wrap at NumEntries
  function automatic logic [EntryIdWidth-1:0] wrap_add(input logic [EntryIdWidth-1:0] base,
                                                       input int unsigned inc);
    int unsigned sum;
    sum = base + inc;
    return EntryIdWidth'(sum % NumEntries);
  endfunction

  assign allocated_entry_count = allocated_count;
  assign free_entry_count = CountWidth'(NumEntries) - allocated_count;

  // Offer is the smaller of free space and beat width
  // Nothing is offered while disabled
  always_comb begin
    if (!alloc_enable) begin
      alloc_sendable = '0;
    end else if (free_entry_count < MaxAllocSize) begin
      alloc_sendable = SizeWidth'(free_entry_count);
    end else begin
      alloc_sendable = SizeWidth'(MaxAllocSize);
    end
  end

  // Lane i carries the i-th next sequential ID
  always_comb begin
    for (int i = 0; i < MaxAllocSize; i++) begin
      alloc_entry_id[i] = wrap_add(alloc_ptr, i);
    end
  end

  // Client takes the lowest lanes, up to what it can receive
  assign taken_count = (alloc_receivable < alloc_sendable) ? alloc_receivable : alloc_sendable;
  assign released_count = dealloc_valid ? dealloc_size : '0;

  assign alloc_ptr_next = wrap_add(alloc_ptr, taken_count);

  // Count moves by taken minus released
  // An over-release empties the queue instead of wrapping the count
  always_comb begin
    count_grow = (CountWidth + 1)'(allocated_count) + (CountWidth + 1)'(taken_count);
    over_release = (CountWidth + 1)'(released_count) > count_grow;
    if (over_release) begin
      count_next = '0;
    end else begin
      count_next = CountWidth'(count_grow - (CountWidth + 1)'(released_count));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      alloc_ptr <= '0;
      allocated_count <= '0;
    end else begin
      alloc_ptr <= alloc_ptr_next;
      allocated_count <= count_next;
    end
  end

endmodule

// File: verilog/tracker_apb_regs.sv
`timescale 1ns/10ps

module tracker_apb_regs #(
  parameter int NumEntries = 8,
  parameter int MaxAllocSize = 3,
  localparam int SizeWidth = $clog2(MaxAllocSize + 1),
  localparam int CountWidth = $clog2(NumEntries + 1)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  tracker_pkg::apb_req_t     apb_req,
  output tracker_pkg::apb_rsp_t     apb_rsp,
  // Status sources
  input  tracker_pkg::tracker_err_t err_flags,
  input  logic [SizeWidth-1:0]      alloc_taken,
  input  logic [CountWidth-1:0]     free_entry_count,
  input  logic [CountWidth-1:0]     allocated_entry_count,
  // Control outputs
  output logic                      alloc_enable,
  output tracker_pkg::tracker_err_t err_clear
);

  localparam int DataW = tracker_pkg::APB_DATA_W;
  localparam int ErrW = $bits(tracker_pkg::tracker_err_t);

  logic             setup_phase;
  logic             access_phase;
  logic             wr_access;
  logic             addr_ok;
  logic [DataW-1:0] rd_mux;
  logic [DataW-1:0] status_word;
  logic [DataW-1:0] alloc_total;
  logic [DataW-1:0] prdata_q;
  logic             pslverr_q;

  assign setup_phase = apb_req.psel && !apb_req.penable;
  assign access_phase = apb_req.psel && apb_req.penable;
  assign wr_access = access_phase && apb_req.pwrite;

  // Free count in the upper byte, allocated count in the lower
  assign status_word = {{(DataW - 2 * tracker_pkg::COUNT_FIELD_W){1'b0}},
                        tracker_pkg::COUNT_FIELD_W'(free_entry_count),
                        tracker_pkg::COUNT_FIELD_W'(allocated_entry_count)};

  // Offset decode and read select
  always_comb begin
    rd_mux = '0;
    addr_ok = 1'b1;
    case (apb_req.paddr)
      tracker_pkg::REG_STATUS:      rd_mux = status_word;
      tracker_pkg::REG_ERROR:       rd_mux = {{(DataW - ErrW){1'b0}}, err_flags};
      tracker_pkg::REG_CTRL:        rd_mux = {{(DataW - 1){1'b0}}, alloc_enable};
      tracker_pkg::REG_ALLOC_TOTAL: rd_mux = alloc_total;
      default:                      addr_ok = 1'b0;
    endcase
  end

  // Response captured in setup, presented during the access phase
  always_ff @(posedge clk) begin
    if (reset) begin
      prdata_q <= '0;
      pslverr_q <= 1'b0;
    end else if (setup_phase) begin
      prdata_q <= apb_req.pwrite ? '0 : rd_mux;
      pslverr_q <= !addr_ok;
    end
  end

  // CTRL lands on the edge closing the access phase
  always_ff @(posedge clk) begin
    if (reset) begin
      alloc_enable <= 1'b0;
    end else if (wr_access && (apb_req.paddr == tracker_pkg::REG_CTRL)) begin
      alloc_enable <= apb_req.pwdata[0];
    end
  end

  // Running total of IDs handed out, wraps at 2^32
  always_ff @(posedge clk) begin
    if (reset) begin
      alloc_total <= '0;
    end else begin
      alloc_total <= alloc_total + DataW'(alloc_taken);
    end
  end

  // One-cycle clear pulse for the sticky flags
  always_comb begin
    err_clear = '0;
    if (wr_access && (apb_req.paddr == tracker_pkg::REG_ERROR)) begin
      err_clear = tracker_pkg::tracker_err_t'(apb_req.pwdata[ErrW-1:0]);
    end
  end

  assign apb_rsp.prdata = prdata_q;
  assign apb_rsp.pready = 1'b1;
  assign apb_rsp.pslverr = pslverr_q;

endmodule

// File: verilog/tracker_monitor.sv
`timescale 1ns/10ps

module tracker_monitor #(
  parameter int NumEntries = 8,
  parameter int MaxAllocSize = 3,
  localparam int EntryIdWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1,
  localparam int SizeWidth = $clog2(MaxAllocSize + 1),
  localparam int CountWidth = $clog2(NumEntries + 1)
) (
  input  logic                                      clk,
  input  logic                                      reset,
  // Observed allocation traffic
  input  logic [SizeWidth-1:0]                      alloc_sendable,
  input  logic [SizeWidth-1:0]                      alloc_receivable,
  input  logic [MaxAllocSize-1:0][EntryIdWidth-1:0] alloc_entry_id,
  // Observed release traffic
  input  logic                                      dealloc_valid,
  input  logic [SizeWidth-1:0]                      dealloc_size,
  // Tracker occupancy under check
  input  logic [CountWidth-1:0]                     free_entry_count,
  input  logic [CountWidth-1:0]                     allocated_entry_count,
  // Write-1-to-clear pulse from software
  input  tracker_pkg::tracker_err_t                 err_clear,
  output tracker_pkg::tracker_err_t                 err_flags,
  output logic [SizeWidth-1:0]                      alloc_taken
);

  // Shadow copy of which entries are held
  logic [NumEntries-1:0]                     shadow;
  logic [NumEntries-1:0]                     shadow_nxt;
  logic [NumEntries-1:0]                     beat_set;
  logic [CountWidth-1:0]                     shadow_count;

  logic [MaxAllocSize-1:0]                   taken_mask;
  logic [MaxAllocSize-1:0]                   rel_mask;
  logic [EntryIdWidth-1:0]                   rel_ptr;
  logic [MaxAllocSize-1:0][EntryIdWidth-1:0] rel_id;

  tracker_pkg::tracker_err_t                 err_hit;

  function automatic logic [EntryIdWidth-1:0] wrap_add(input logic [EntryIdWidth-1:0] base,
                                                       input int unsigned inc);
    int unsigned sum;
    sum = base + inc;
    return EntryIdWidth'(sum % NumEntries);
  endfunction

  function automatic logic [CountWidth-1:0] popcount(input logic [NumEntries-1:0] bits);
    logic [CountWidth-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < NumEntries; i++) begin
      cnt = cnt + CountWidth'(bits[i]);
    end
    return cnt;
  endfunction

  // Taken this beat is the smaller of offer and receivable
  assign alloc_taken = (alloc_sendable > alloc_receivable) ? alloc_receivable : alloc_sendable;

  // Lane masks for taken and released IDs
  // Release IDs follow the monitor's own pointer, independent of the tracker
  always_comb begin
    for (int i = 0; i < MaxAllocSize; i++) begin
      taken_mask[i] = (i < alloc_taken);
      rel_mask[i] = dealloc_valid && (i < dealloc_size);
      rel_id[i] = wrap_add(rel_ptr, i);
    end
  end

  // Apply releases, then allocations, and look for reuse on the way
  always_comb begin
    shadow_nxt = shadow;
    beat_set = '0;
    err_hit = '0;
    for (int i = 0; i < MaxAllocSize; i++) begin
      if (rel_mask[i]) begin
        shadow_nxt[rel_id[i]] = 1'b0;
      end
    end
    for (int i = 0; i < MaxAllocSize; i++) begin
      if (taken_mask[i]) begin
        // Already held, or handed out twice in one beat
        if (shadow[alloc_entry_id[i]] || beat_set[alloc_entry_id[i]]) begin
          err_hit.reuse = 1'b1;
        end
        beat_set[alloc_entry_id[i]] = 1'b1;
        shadow_nxt[alloc_entry_id[i]] = 1'b1;
      end
    end
    // Releasing more than is held
    if (dealloc_valid && (dealloc_size > shadow_count)) begin
      err_hit.over_release = 1'b1;
    end
    // Both tracker counts must agree with the shadow population
    if ((shadow_count != allocated_entry_count) ||
        ((CountWidth'(NumEntries) - shadow_count) != free_entry_count)) begin
      err_hit.count_mismatch = 1'b1;
    end
  end

  assign shadow_count = popcount(shadow);

  always_ff @(posedge clk) begin
    if (reset) begin
      shadow <= '0;
      rel_ptr <= '0;
      err_flags <= '0;
    end else begin
      shadow <= shadow_nxt;
      if (dealloc_valid) begin
        rel_ptr <= wrap_add(rel_ptr, dealloc_size);
      end
      // A new fault in the clearing cycle still sticks
      err_flags <= tracker_pkg::tracker_err_t'((err_flags & ~err_clear) | err_hit);
    end
  end

endmodule

// File: verilog/tracker_pkg.sv
package tracker_pkg;

  // APB bus geometry for the register window
  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 32;

  // Each count takes one byte of the STATUS word
  // This caps NumEntries at 255
  localparam int COUNT_FIELD_W = 8;

  // Register offsets, word aligned
  localparam logic [APB_ADDR_W-1:0] REG_STATUS      = 4'h0;
  localparam logic [APB_ADDR_W-1:0] REG_ERROR       = 4'h4;
  localparam logic [APB_ADDR_W-1:0] REG_CTRL        = 4'h8;
  localparam logic [APB_ADDR_W-1:0] REG_ALLOC_TOTAL = 4'hC;

  // Sticky monitor flags
  // reuse sits in bit 0 of the ERROR register
  typedef struct packed {
    logic count_mismatch;
    logic over_release;
    logic reuse;
  } tracker_err_t;

  // Requester side of the APB slave
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Completer side of the APB slave
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

// File: verilog/tracker_top.sv
`timescale 1ns/10ps

module tracker_top #(
  parameter int NumEntries = 8,
  parameter int MaxAllocSize = 3,
  localparam int EntryIdWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1,
  localparam int SizeWidth = $clog2(MaxAllocSize + 1),
  localparam int CountWidth = $clog2(NumEntries + 1)
) (
  input  logic                                      clk,
  input  logic                                      reset,
  // Client allocation port
  input  logic [SizeWidth-1:0]                      alloc_receivable,
  output logic [SizeWidth-1:0]                      alloc_sendable,
  output logic [MaxAllocSize-1:0][EntryIdWidth-1:0] alloc_entry_id,
  // Client release port
  input  logic                                      dealloc_valid,
  input  logic [SizeWidth-1:0]                      dealloc_size,
  output logic [CountWidth-1:0]                     free_entry_count,
  output logic [CountWidth-1:0]                     allocated_entry_count,
  // Register window
  input  tracker_pkg::apb_req_t                     apb_req,
  output tracker_pkg::apb_rsp_t                     apb_rsp
);

  logic                      alloc_enable;
  logic [SizeWidth-1:0]      alloc_taken;
  tracker_pkg::tracker_err_t err_flags;
  tracker_pkg::tracker_err_t err_clear;

  // ID allocator
  seq_tracker #(
    .NumEntries  (NumEntries),
    .MaxAllocSize(MaxAllocSize)
  ) u_tracker (
    .clk                  (clk),
    .reset                (reset),
    .alloc_enable         (alloc_enable),
    .alloc_receivable     (alloc_receivable),
    .alloc_sendable       (alloc_sendable),
    .alloc_entry_id       (alloc_entry_id),
    .dealloc_valid        (dealloc_valid),
    .dealloc_size         (dealloc_size),
    .free_entry_count     (free_entry_count),
    .allocated_entry_count(allocated_entry_count)
  );

  // Shadow checker watching the same ports as the client
  tracker_monitor #(
    .NumEntries  (NumEntries),
    .MaxAllocSize(MaxAllocSize)
  ) u_monitor (
    .clk                  (clk),
    .reset                (reset),
    .alloc_sendable       (alloc_sendable),
    .alloc_receivable     (alloc_receivable),
    .alloc_entry_id       (alloc_entry_id),
    .dealloc_valid        (dealloc_valid),
    .dealloc_size         (dealloc_size),
    .free_entry_count     (free_entry_count),
    .allocated_entry_count(allocated_entry_count),
    .err_clear            (err_clear),
    .err_flags            (err_flags),
    .alloc_taken          (alloc_taken)
  );

  tracker_apb_regs #(
    .NumEntries  (NumEntries),
    .MaxAllocSize(MaxAllocSize)
  ) u_regs (
    .clk                  (clk),
    .reset                (reset),
    .apb_req              (apb_req),
    .apb_rsp              (apb_rsp),
    .err_flags            (err_flags),
    .alloc_taken          (alloc_taken),
    .free_entry_count     (free_entry_count),
    .allocated_entry_count(allocated_entry_count),
    .alloc_enable         (alloc_enable),
    .err_clear            (err_clear)
  );

endmodule
